/* logic/rv_isa_pkg.sv */
/*
 * RISC-V load/store encodings
 * Funct3 size/sign codes shared by the data memory and its checker
 * Widest supported XLEN
 */
`default_nettype none

package rv_isa_pkg;

  // Widest data path, sets every data field width
  localparam int XLEN_MAX = 64;

  // Store codes use the same values for size
  // LB / SB
  localparam logic [2:0] F3_B  = 3'b000;
  // LH / SH
  localparam logic [2:0] F3_H  = 3'b001;
  // LW / SW
  localparam logic [2:0] F3_W  = 3'b010;
  // LD / SD, RV64 only
  localparam logic [2:0] F3_D  = 3'b011;

  // Unsigned loads, no store counterpart
  localparam logic [2:0] F3_BU = 3'b100; // LBU
  localparam logic [2:0] F3_HU = 3'b101; // LHU
  localparam logic [2:0] F3_WU = 3'b110; // LWU, RV64 only

  // Code 111 is unused, loads return zero and stores are dropped

endpackage

`default_nettype wire

/* logic/dmem_pkg.sv */
/*
 * Data memory types
 * Width constants, request struct, per-lane bank command
 * and the load control carried to the aligner
 */
`default_nettype none

package dmem_pkg;

  localparam int LANES_MAX = rv_isa_pkg::XLEN_MAX / 8; // 8 lanes in RV64
  localparam int BYTE_W    = 8;  // One lane
  localparam int ROW_W     = 16; // Rows of a 64 KB memory
  localparam int OFF_W     = 3;  // Lane offset inside a row

  // One request per cycle, write wins over read
  typedef struct packed {
    logic                              rd;     // Load strobe
    logic                              wr;     // Store strobe
    logic [2:0]                        funct3; // Size and sign
    logic [rv_isa_pkg::XLEN_MAX-1:0]   addr;   // Byte address
    logic [rv_isa_pkg::XLEN_MAX-1:0]   wdata;  // Store data, right aligned
  } mem_req_t;

  // Command to one byte bank
  typedef struct packed {
    logic               we;
    logic               re;
    logic [ROW_W-1:0]   row;   // Row inside the bank
    logic [BYTE_W-1:0]  wbyte; // Already rotated onto this lane
  } lane_req_t;

  // Load info held across the bank read
  typedef struct packed {
    logic               valid;  // Load accepted this cycle
    logic [2:0]         funct3; // 111 means return zero
    logic [OFF_W-1:0]   offset; // First lane of the access
  } load_ctl_t;

endpackage

`default_nettype wire

/* logic/store_lane_steer.sv */
/*
 * Request decode for the byte-lane memory
 * Address masking and alignment, per-lane write enables,
 * store byte rotation, load control for the aligner
 */
`default_nettype none

module store_lane_steer #(
  parameter int XLEN     = 64,
  parameter int MEM_SIZE = 65536
) (
  input  dmem_pkg::mem_req_t                             req,
  output dmem_pkg::lane_req_t [dmem_pkg::LANES_MAX-1:0]  lane_req,
  output dmem_pkg::load_ctl_t                            load_ctl
);

  localparam int LANES     = XLEN / 8;
  localparam int LANE_BITS = $clog2(LANES);
  localparam int ADDR_BITS = $clog2(MEM_SIZE);

  logic [ADDR_BITS-1:0]            maddr;      // Address wrapped into memory
  logic [dmem_pkg::ROW_W-1:0]      row_idx;
  logic [dmem_pkg::OFF_W-1:0]      off_raw;
  logic [dmem_pkg::OFF_W-1:0]      align_mask; // Clears offset bits below size
  logic [dmem_pkg::OFF_W-1:0]      off_al;
  logic                            is_load;
  logic                            st_legal;
  logic                            ld_legal;
  logic                            st_en;

  assign maddr = req.addr[ADDR_BITS-1:0]; // Same as addr & (MEM_SIZE-1)

  always_comb begin
    row_idx = '0;
    row_idx[ADDR_BITS-LANE_BITS-1:0] = maddr[ADDR_BITS-1:LANE_BITS];
  end

  // Lane offset with bit 2 dropped in RV32
  assign off_raw    = maddr[2:0] & 3'(LANES - 1);
  assign align_mask = 3'b111 << req.funct3[1:0];
  assign off_al     = off_raw & align_mask; // H, W, D forced to natural alignment

  // Only 000..011 are stores and SD needs RV64
  assign st_legal = !req.funct3[2] && !(XLEN == 32 && req.funct3 == rv_isa_pkg::F3_D);
  assign ld_legal = !(XLEN == 32 && (req.funct3 == rv_isa_pkg::F3_D ||
                                     req.funct3 == rv_isa_pkg::F3_WU));

  assign is_load = req.rd && !req.wr; // Write wins
  assign st_en   = req.wr && st_legal;

  for (genvar i = 0; i < dmem_pkg::LANES_MAX; i++) begin : g_lane
    localparam logic [dmem_pkg::OFF_W-1:0] LANE_ID = 3'(i);
    if (i < LANES) begin : g_used
      logic [dmem_pkg::OFF_W-1:0] src; // Source byte in wdata
      assign src = LANE_ID - off_al;
      // Lane is covered when it shares the aligned block with the offset
      assign lane_req[i].we    = st_en && (((LANE_ID ^ off_al) & align_mask) == 3'b000);
      assign lane_req[i].re    = is_load;
      assign lane_req[i].row   = row_idx;
      assign lane_req[i].wbyte = req.wdata[{src, 3'b000} +: dmem_pkg::BYTE_W];
    end else begin : g_idle
      assign lane_req[i] = '0; // Upper lanes in RV32
    end
  end

  assign load_ctl.valid  = is_load;
  assign load_ctl.funct3 = ld_legal ? req.funct3 : 3'b111; // Illegal code reads as zero
  assign load_ctl.offset = off_al;

endmodule

`default_nettype wire

/* logic/dmem_byte_bank.sv */
/*
 * One byte lane of the data memory
 * Synchronous write, registered read of old contents
 */
`default_nettype none

module dmem_byte_bank #(
  parameter int DEPTH = 8192
) (
  input  logic                          clk,
  input  dmem_pkg::lane_req_t           lane_req,
  output logic [dmem_pkg::BYTE_W-1:0]   rbyte
);

  localparam int AW = $clog2(DEPTH);

  logic [dmem_pkg::BYTE_W-1:0] mem [DEPTH];
  logic [AW-1:0]               row;

  // Upper row bits are zero for this depth
  assign row = lane_req.row[AW-1:0];

  // Banks come up cleared
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (lane_req.we) begin
      mem[row] <= lane_req.wbyte;
    end
    if (lane_req.re) begin
      rbyte <= mem[row]; // Holds until next read
    end
  end

endmodule

`default_nettype wire

/* logic/load_align_extend.sv */
/*
 * Load return path
 * Registers load control alongside the bank read, then
 * selects the addressed bytes and sign or zero extends them
 */
`default_nettype none

module load_align_extend #(
  parameter int XLEN = 64
) (
  input  logic                                                clk,
  input  logic                                                reset,
  input  dmem_pkg::load_ctl_t                                 load_ctl,
  input  logic [dmem_pkg::LANES_MAX-1:0][dmem_pkg::BYTE_W-1:0] rdata_lanes,
  output logic                                                rsp_valid,
  output logic [rv_isa_pkg::XLEN_MAX-1:0]                     rsp_data
);

  dmem_pkg::load_ctl_t               ctl_q;
  logic [rv_isa_pkg::XLEN_MAX-1:0]   row_bytes;
  logic [rv_isa_pkg::XLEN_MAX-1:0]   shifted;
  logic [rv_isa_pkg::XLEN_MAX-1:0]   ext;

  always_ff @(posedge clk) begin
    if (reset) begin
      ctl_q.valid <= 1'b0;
    end else begin
      ctl_q.valid <= load_ctl.valid;
    end
    ctl_q.funct3 <= load_ctl.funct3;
    ctl_q.offset <= load_ctl.offset;
  end

  assign row_bytes = rdata_lanes;                              // Lane 0 is the low byte
  assign shifted   = row_bytes >> {ctl_q.offset, 3'b000};      // Access moved to bit 0

  always_comb begin
    case (ctl_q.funct3)
      rv_isa_pkg::F3_B:  ext = {{56{shifted[7]}}, shifted[7:0]};
      rv_isa_pkg::F3_H:  ext = {{48{shifted[15]}}, shifted[15:0]};
      rv_isa_pkg::F3_W:  ext = {{32{shifted[31]}}, shifted[31:0]};
      rv_isa_pkg::F3_BU: ext = {56'h0, shifted[7:0]};
      rv_isa_pkg::F3_HU: ext = {48'h0, shifted[15:0]};
      rv_isa_pkg::F3_D: begin
        ext = (XLEN == 64) ? shifted : '0; // No LD in RV32
      end
      rv_isa_pkg::F3_WU: begin
        ext = (XLEN == 64) ? {32'h0, shifted[31:0]} : '0;
      end
      default: ext = '0; // Code 111
    endcase
  end

  // RV32 keeps only the low word, sign already applied at bit 31
  assign rsp_data  = (XLEN == 32) ? {32'h0, ext[31:0]} : ext;
  assign rsp_valid = ctl_q.valid; // One cycle after each load

endmodule

`default_nettype wire

/* logic/data_memory_top.sv */
/*
 * Data memory top level
 * Steering block, array of byte banks, load aligner
 */
`default_nettype none

module data_memory_top #(
  parameter int XLEN     = 64,
  parameter int MEM_SIZE = 65536
) (
  input  logic                              clk,
  input  logic                              reset,
  input  dmem_pkg::mem_req_t                req,
  output logic                              rsp_valid,
  output logic [rv_isa_pkg::XLEN_MAX-1:0]   rsp_data
);

  localparam int LANES = XLEN / 8;

  dmem_pkg::lane_req_t [dmem_pkg::LANES_MAX-1:0]                lane_req;
  dmem_pkg::load_ctl_t                                          load_ctl;
  logic [dmem_pkg::LANES_MAX-1:0][dmem_pkg::BYTE_W-1:0]         rdata_lanes;

  store_lane_steer #(
    .XLEN     (XLEN),
    .MEM_SIZE (MEM_SIZE)
  ) i_steer (
    .req      (req),
    .lane_req (lane_req),
    .load_ctl (load_ctl)
  );

  for (genvar i = 0; i < dmem_pkg::LANES_MAX; i++) begin : g_bank
    if (i < LANES) begin : g_used
      dmem_byte_bank #(
        .DEPTH    (MEM_SIZE / LANES)
      ) i_bank (
        .clk      (clk),
        .lane_req (lane_req[i]),
        .rbyte    (rdata_lanes[i])
      );
    end else begin : g_absent
      assign rdata_lanes[i] = '0; // No bank above XLEN
    end
  end

  load_align_extend #(
    .XLEN        (XLEN)
  ) i_align (
    .clk         (clk),
    .reset       (reset),
    .load_ctl    (load_ctl),
    .rdata_lanes (rdata_lanes),
    .rsp_valid   (rsp_valid),
    .rsp_data    (rsp_data)
  );

endmodule

`default_nettype wire

/* sim/dmem_checker.sv */
/*
 * Scoreboard for the data memory
 * Byte-array reference model, one-deep expected response,
 * rsp_valid and load data comparison with error counts
 */
`default_nettype none

module dmem_checker #(
  parameter int MEM_SIZE = 1024
) (
  input  logic                            clk,
  input  logic                            reset,
  input  dmem_pkg::mem_req_t              req,
  input  logic                            rsp_valid,
  input  logic [rv_isa_pkg::XLEN_MAX-1:0] rsp_data,
  output logic                            load_pending, // Response due next cycle
  output int                              load_checks,
  output int                              value_errors,
  output int                              valid_errors
);

  logic [7:0]                      model [MEM_SIZE]; // Reference bytes
  logic [rv_isa_pkg::XLEN_MAX-1:0] exp_data;
  logic [rv_isa_pkg::XLEN_MAX-1:0] exp_addr;
  logic [2:0]                      exp_funct3;
  logic                            primed; // Skips the first edge, outputs still X

  initial begin
    for (int i = 0; i < MEM_SIZE; i++) begin
      model[i] = 8'h00; // Banks start cleared
    end
    load_pending = 1'b0;
    primed       = 1'b0;
    load_checks  = 0;
    value_errors = 0;
    valid_errors = 0;
  end

  // 1, 2, 4 or 8 bytes
  function automatic int access_bytes(logic [2:0] funct3);
    return 1 << funct3[1:0];
  endfunction

  // Wrap into the memory, then round down to the access size
  function automatic int aligned_base(logic [63:0] addr, logic [2:0] funct3);
    int a;
    a = int'(addr % 64'(MEM_SIZE));
    return a - (a % access_bytes(funct3));
  endfunction

  function automatic string load_name(logic [2:0] funct3);
    case (funct3)
      rv_isa_pkg::F3_B:  return "LB";
      rv_isa_pkg::F3_H:  return "LH";
      rv_isa_pkg::F3_W:  return "LW";
      rv_isa_pkg::F3_D:  return "LD";
      rv_isa_pkg::F3_BU: return "LBU";
      rv_isa_pkg::F3_HU: return "LHU";
      rv_isa_pkg::F3_WU: return "LWU";
      default:           return "LOAD_111";
    endcase
  endfunction

  // Little-endian gather, then extension by funct3
  function automatic logic [63:0] expected_load(logic [63:0] addr, logic [2:0] funct3);
    logic [63:0] raw;
    int          base;
    raw  = '0;
    base = aligned_base(addr, funct3);
    for (int i = 0; i < access_bytes(funct3); i++) begin
      raw[8*i +: 8] = model[base + i];
    end
    case (funct3)
      rv_isa_pkg::F3_B: return 64'($signed(raw[7:0]));
      rv_isa_pkg::F3_H: return 64'($signed(raw[15:0]));
      rv_isa_pkg::F3_W: return 64'($signed(raw[31:0]));
      rv_isa_pkg::F3_D, rv_isa_pkg::F3_BU, rv_isa_pkg::F3_HU, rv_isa_pkg::F3_WU: begin
        return raw; // Bytes above the size stay zero
      end
      default: return '0; // Code 111
    endcase
  endfunction

  // Only 000..011 write, 1xx leaves the model alone
  task automatic apply_store(logic [63:0] addr, logic [2:0] funct3, logic [63:0] wdata);
    int base;
    base = aligned_base(addr, funct3);
    if (!funct3[2]) begin
      for (int i = 0; i < access_bytes(funct3); i++) begin
        model[base + i] = wdata[8*i +: 8];
      end
    end
  endtask

  always @(posedge clk) begin
    if (primed) begin
      // Compare what the DUT shows for the previous edge
      if (rsp_valid !== load_pending) begin
        $display("CHECK FAILED rsp_valid at %0t: expected %b actual %b",
                 $time, load_pending, rsp_valid);
        valid_errors <= valid_errors + 1;
      end else if (load_pending) begin
        load_checks <= load_checks + 1;
        if (rsp_data !== exp_data) begin
          $display("CHECK FAILED %s addr=%h: expected %h actual %h",
                   load_name(exp_funct3), exp_addr, exp_data, rsp_data);
          value_errors <= value_errors + 1;
        end
      end
    end
    primed <= 1'b1;
    if (reset) begin
      load_pending <= 1'b0; // Nothing valid out of reset
    end else begin
      load_pending <= req.rd && !req.wr; // Write wins
      exp_data     <= expected_load(req.addr, req.funct3);
      exp_addr     <= req.addr;
      exp_funct3   <= req.funct3;
      if (req.wr) begin
        apply_store(req.addr, req.funct3, req.wdata);
      end
    end
  end

endmodule

`default_nettype wire

/* sim/dmem_tb.sv */
/*
 * Testbench top for the byte-lane data memory
 * Clock, reset, seeded random load/store stimulus,
 * DUT and checker instances, cycle timeout
 */
`default_nettype none

module dmem_tb;

  localparam int XLEN           = 64;
  localparam int MEM_SIZE       = 1024; // Small enough that locations get reused
  localparam int NUM_REQS       = 3000;
  localparam int RESET_CYCLES   = 5;
  localparam int TIMEOUT_CYCLES = NUM_REQS + 200;

  logic                            clk;
  logic                            reset;
  dmem_pkg::mem_req_t              req;
  logic                            rsp_valid;
  logic [rv_isa_pkg::XLEN_MAX-1:0] rsp_data;
  logic                            load_pending;
  int                              load_checks;
  int                              value_errors;
  int                              valid_errors;
  int                              cycle_count;

  always #4 clk = ~clk; // Period 8

  data_memory_top #(
    .XLEN      (XLEN),
    .MEM_SIZE  (MEM_SIZE)
  ) i_dut (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data)
  );

  dmem_checker #(
    .MEM_SIZE     (MEM_SIZE)
  ) i_checker (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .rsp_valid    (rsp_valid),
    .rsp_data     (rsp_data),
    .load_pending (load_pending),
    .load_checks  (load_checks),
    .value_errors (value_errors),
    .valid_errors (valid_errors)
  );

  // About 45% store, 45% load, 10% idle
  task automatic drive_random_req();
    int                 kind;
    dmem_pkg::mem_req_t r;
    kind     = int'($urandom_range(99, 0));
    r        = '0;
    r.funct3 = 3'($urandom_range(7, 0));        // All eight codes
    r.addr   = 64'($urandom_range(4095, 0));    // Up to 4x MEM_SIZE for aliasing
    r.wdata  = {$urandom(), $urandom()};
    r.wr     = (kind < 45);
    r.rd     = ((kind >= 45) && (kind < 90)) || (kind < 5); // A few stores also raise rd
    req <= r;
  endtask

  // Run limit that ends any hang
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h6690));
    clk         = 1'b0;
    reset       = 1'b1;
    req         = '0;
    req.rd      = 1'b1; // Load held through reset gets no response
    cycle_count = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < NUM_REQS; i++) begin
      drive_random_req();
      @(posedge clk);
    end
    req <= '0;
    // Wait for the last load response to be compared
    do begin
      @(posedge clk);
    end while (load_pending);
    @(posedge clk);
    $display("Checks: %0d loads compared, %0d value errors, %0d valid errors",
             load_checks, value_errors, valid_errors);
    if (value_errors == 0 && valid_errors == 0 && load_checks > 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
logic/rv_isa_pkg.sv
logic/dmem_pkg.sv
logic/store_lane_steer.sv
logic/dmem_byte_bank.sv
logic/load_align_extend.sv
logic/data_memory_top.sv
sim/dmem_checker.sv
sim/dmem_tb.sv

/* Makefile */
# Verilator build and run of the data memory testbench

TOP = dmem_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f src.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
